/* design/addsub_pkg.sv */
`default_nettype none

package addsub_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int WORD_W      = 128;
    localparam int LANE_W      = 32;
    localparam int NUM_LANES   = WORD_W / LANE_W;

    // Depth of the up-sweep in the prefix tree.
    localparam int PREFIX_LVLS = $clog2(LANE_W);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } addsub_op_e;

    typedef struct packed {
        addsub_op_e        op;
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
    } addsub_req_t;

    // Travels down the lane pipeline; b is already inverted for subtraction.
    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [WORD_W-1:0] sum;
        logic              carry;
    } lane_bus_t;

    typedef struct packed {
        logic carry;
        logic overflow;
        logic zero;
        logic negative;
    } addsub_flags_t;

    typedef struct packed {
        logic [WORD_W-1:0] sum;
        addsub_flags_t     flags;
    } addsub_result_t;

endpackage

`default_nettype wire

/* design/brent_kung_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module brent_kung_adder
    import addsub_pkg::*;
(
    input  wire logic [LANE_W-1:0] a_i,
    input  wire logic [LANE_W-1:0] b_i,
    input  wire logic              carry_i,
    output logic      [LANE_W-1:0] sum_o,
    output logic                   carry_o
);

    logic [LANE_W-1:0] p_bit;
    logic [LANE_W-1:0] g_bit;
    logic [LANE_W-1:0] x_bit;

    // Level l holds group terms of width 2**l at positions (j+1) % 2**l == 0.
    logic [LANE_W-1:0] g_up [PREFIX_LVLS+1];
    logic [LANE_W-1:0] p_up [PREFIX_LVLS+1];

    // Each down-sweep level turns more group terms into full prefixes.
    logic [LANE_W-1:0] g_dn [PREFIX_LVLS];

    logic [LANE_W-1:0] g_final;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit terms.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        p_bit = a_i | b_i;
        g_bit = a_i & b_i;
        // Carry-in behaves like a generate from position -1.
        g_bit[0] = g_bit[0] | (p_bit[0] & carry_i);
    end

    assign x_bit = a_i ^ b_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Up-sweep.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign g_up[0] = g_bit;
    assign p_up[0] = p_bit;

    for (genvar l = 0; l < PREFIX_LVLS; l++) begin : g_up_lvl
        for (genvar j = 0; j < LANE_W; j++) begin : g_pos
            if (((j + 1) % (2 ** (l + 1))) == 0) begin : g_node
                assign g_up[l+1][j] = g_up[l][j] | (p_up[l][j] & g_up[l][j - 2 ** l]);
                assign p_up[l+1][j] = p_up[l][j] & p_up[l][j - 2 ** l];
            end else begin : g_pass
                assign g_up[l+1][j] = g_up[l][j];
                assign p_up[l+1][j] = p_up[l][j];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Down-sweep.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Positions 2**k - 1 are already full prefixes after the up-sweep.
    assign g_dn[0] = g_up[PREFIX_LVLS];

    for (genvar s = 0; s < PREFIX_LVLS - 1; s++) begin : g_dn_lvl
        for (genvar j = 0; j < LANE_W; j++) begin : g_pos
            if ((((j + 1) % (2 ** (PREFIX_LVLS - 1 - s))) == 2 ** (PREFIX_LVLS - 2 - s))
                && ((j + 1) > 2 ** (PREFIX_LVLS - 1 - s))) begin : g_node
                // Group term at j is untouched by later up-sweep levels.
                assign g_dn[s+1][j] = g_dn[s][j]
                    | (p_up[PREFIX_LVLS][j] & g_dn[s][j - 2 ** (PREFIX_LVLS - 2 - s)]);
            end else begin : g_pass
                assign g_dn[s+1][j] = g_dn[s][j];
            end
        end
    end

    assign g_final = g_dn[PREFIX_LVLS-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sum.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign sum_o   = x_bit ^ {g_final[LANE_W-2:0], carry_i};
    assign carry_o = g_final[LANE_W-1];

endmodule

`default_nettype wire

/* design/operand_prep.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_prep
    import addsub_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic        req_valid_i,
    input  wire addsub_req_t req_i,
    output lane_bus_t        bus_o
);

    logic              valid_q;
    logic [WORD_W-1:0] a_q;
    logic [WORD_W-1:0] b_q;
    logic              carry_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid_i;
        end
    end

    // Subtract as a + ~b + 1.
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            a_q     <= req_i.a;
            b_q     <= (req_i.op == OP_SUB) ? ~req_i.b : req_i.b;
            carry_q <= (req_i.op == OP_SUB);
        end
    end

    always_comb begin
        bus_o.valid = valid_q;
        bus_o.a     = a_q;
        bus_o.b     = b_q;
        bus_o.sum   = '0;
        bus_o.carry = carry_q;
    end

    // An undefined opcode would silently pick a direction.
    a_op_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i |-> (!$isunknown(req_i.op) && (req_i.op inside {OP_ADD, OP_SUB}))
    );

endmodule

`default_nettype wire

/* design/carry_lane_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module carry_lane_stage
    import addsub_pkg::*;
#(
    parameter int LANE = 0
) (
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire lane_bus_t bus_i,
    output lane_bus_t      bus_o
);

    logic [LANE_W-1:0] slice_sum;
    logic              slice_carry;
    logic [WORD_W-1:0] sum_next;

    logic              valid_q;
    logic [WORD_W-1:0] a_q;
    logic [WORD_W-1:0] b_q;
    logic [WORD_W-1:0] sum_q;
    logic              carry_q;

    brent_kung_adder i_adder (
        .a_i     (bus_i.a[LANE*LANE_W +: LANE_W]),
        .b_i     (bus_i.b[LANE*LANE_W +: LANE_W]),
        .carry_i (bus_i.carry),
        .sum_o   (slice_sum),
        .carry_o (slice_carry)
    );

    // Lower slices are already filled in by earlier stages.
    always_comb begin
        sum_next = bus_i.sum;
        sum_next[LANE*LANE_W +: LANE_W] = slice_sum;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= bus_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_i.valid) begin
            a_q     <= bus_i.a;
            b_q     <= bus_i.b;
            sum_q   <= sum_next;
            carry_q <= slice_carry;
        end
    end

    always_comb begin
        bus_o.valid = valid_q;
        bus_o.a     = a_q;
        bus_o.b     = b_q;
        bus_o.sum   = sum_q;
        bus_o.carry = carry_q;
    end

    a_valid_follows: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) |-> (bus_o.valid == $past(bus_i.valid))
    );

endmodule

`default_nettype wire

/* design/result_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module result_assembler
    import addsub_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire lane_bus_t bus_i,
    output logic           res_valid_o,
    output addsub_result_t res_o
);

    addsub_flags_t     flags_d;

    logic              valid_q;
    logic [WORD_W-1:0] sum_q;
    addsub_flags_t     flags_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Status flags.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        // For subtraction this is the no-borrow bit.
        flags_d.carry    = bus_i.carry;
        // Like signs in, other sign out.
        flags_d.overflow = (bus_i.a[WORD_W-1] == bus_i.b[WORD_W-1])
                           && (bus_i.sum[WORD_W-1] != bus_i.a[WORD_W-1]);
        flags_d.zero     = ~|bus_i.sum;
        flags_d.negative = bus_i.sum[WORD_W-1];
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= bus_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_i.valid) begin
            sum_q   <= bus_i.sum;
            flags_q <= flags_d;
        end
    end

    assign res_valid_o = valid_q;

    always_comb begin
        res_o.sum   = sum_q;
        res_o.flags = flags_q;
    end

    a_zero_not_neg: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        res_valid_o |-> !(res_o.flags.zero && res_o.flags.negative)
    );

endmodule

`default_nettype wire

/* design/wide_addsub_top.sv */
`timescale 1ns/1ps
`default_nettype none

module wide_addsub_top
    import addsub_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic        req_valid_i,
    input  wire addsub_req_t req_i,
    output logic             res_valid_o,
    output addsub_result_t   res_o
);

    // Entry k feeds lane k; the last entry feeds the assembler.
    lane_bus_t lane_bus [NUM_LANES+1];

    operand_prep i_prep (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .bus_o       (lane_bus[0])
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Carry-skewed lanes, least significant slice first.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        carry_lane_stage #(
            .LANE (k)
        ) i_lane (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .bus_i   (lane_bus[k]),
            .bus_o   (lane_bus[k+1])
        );
    end

    result_assembler i_asm (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .bus_i       (lane_bus[NUM_LANES]),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

endmodule

`default_nettype wire

/* test/tb_wide_addsub.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wide_addsub
    import addsub_pkg::*;
();

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 8;
    localparam int    LATENCY      = 6;
    localparam int    BURST_LEN    = 8;
    localparam int    MAX_VEC      = 64;
    localparam int    WAIT_LIMIT   = 200;
    localparam string VEC_FILE     = "test/addsub_input.txt";

    logic           clk;
    logic           rst_n;
    logic           req_valid;
    addsub_req_t    req;
    logic           res_valid;
    addsub_result_t res;

    integer         seed;
    int             cycle = 0;
    int             num_vec;

    addsub_req_t    vec_req [MAX_VEC];
    addsub_result_t vec_exp [MAX_VEC];

    // Expected results in issue order, with the cycle of each issue.
    addsub_result_t exp_q [$];
    int             issue_q [$];

    addsub_result_t head_exp;
    int             head_cycle;

    wide_addsub_top i_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .res_valid_o (res_valid),
        .res_o       (res)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_result(input addsub_result_t got, input addsub_result_t exp);
        if (got.sum !== exp.sum) begin
            abort_run($sformatf("error: res_o.sum got 0x%h expected 0x%h", got.sum, exp.sum));
        end
    endtask

    task automatic check_flags(input addsub_flags_t got, input addsub_flags_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error: res_o.flags got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic load_vectors();
        int                fd;
        int                fields;
        string             line;
        logic [3:0]        op_v;
        logic [WORD_W-1:0] a_v;
        logic [WORD_W-1:0] b_v;
        logic [WORD_W-1:0] sum_v;
        logic [3:0]        flags_v;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            abort_run({"cannot open the vector file ", VEC_FILE});
        end else begin
            num_vec = 0;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip blank and comment lines.
                if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                    continue;
                end
                fields = $sscanf(line, "%h %h %h %h %b", op_v, a_v, b_v, sum_v, flags_v);
                if (fields != 5 || op_v > 4'd1 || num_vec >= MAX_VEC) begin
                    abort_run({"the vector file has a bad line: ", line});
                end else begin
                    vec_req[num_vec].op    = addsub_op_e'(op_v[0]);
                    vec_req[num_vec].a     = a_v;
                    vec_req[num_vec].b     = b_v;
                    vec_exp[num_vec].sum   = sum_v;
                    vec_exp[num_vec].flags = addsub_flags_t'(flags_v);
                    num_vec++;
                end
            end
            $fclose(fd);
            if (num_vec == 0) begin
                abort_run("the vector file holds no vectors");
            end
        end
    endtask

    task automatic issue_request(input addsub_req_t r, input addsub_result_t exp);
        req_valid = 1'b1;
        req       = r;
        exp_q.push_back(exp);
        issue_q.push_back(cycle);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result monitor, sampled on the falling edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        if (!rst_n) begin
            if (res_valid !== 1'b0) begin
                abort_run("res_valid_o was not low during reset");
            end
        end else if (res_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                abort_run("a result appeared with no request outstanding");
            end else begin
                head_exp   = exp_q.pop_front();
                head_cycle = issue_q.pop_front();
                if (cycle - head_cycle != LATENCY) begin
                    abort_run($sformatf("a result came %0d cycles after its request, not %0d",
                                        cycle - head_cycle, LATENCY));
                end else begin
                    check_result(res, head_exp);
                    check_flags(res.flags, head_exp.flags);
                end
            end
        end else if (res_valid !== 1'b0) begin
            abort_run("res_valid_o is unknown after reset");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int gap;
        int wait_cnt;
        seed      = 32'ha0fb_0708;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        load_vectors();

        wait_cnt = 0;
        while (cycle < RESET_CYCLES) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) begin
                abort_run("timeout while holding reset");
            end
        end
        rst_n = 1'b1;

        // Idle after reset; nothing may come out yet.
        repeat (4) @(negedge clk);

        // The first vectors go back to back, the rest with random gaps.
        for (int idx = 0; idx < num_vec; idx++) begin
            gap = 0;
            if (idx >= BURST_LEN) begin
                gap = $unsigned($random(seed)) % 4;
            end
            req_valid = 1'b0;
            repeat (gap) @(negedge clk);
            issue_request(vec_req[idx], vec_exp[idx]);
            @(negedge clk);
        end
        req_valid = 1'b0;

        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < WAIT_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        // A few more cycles to catch a stray result.
        repeat (4) @(negedge clk);

        if (exp_q.size() != 0) begin
            abort_run($sformatf("timeout with %0d results still missing", exp_q.size()));
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* test/addsub_input.txt */
# Columns: op (0 add, 1 sub), a, b, expected sum, all 128-bit hex, then flags.
# Flags are 4 binary digits in the order carry, overflow, zero, negative.
0 ffffffffffffffffffffffffffffffff 00000000000000000000000000000001 00000000000000000000000000000000 1010
0 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 0010
0 00000000000000000000000000000001 00000000000000000000000000000002 00000000000000000000000000000003 0000
0 00000000ffffffffffffffffffffffff 00000000000000000000000000000001 00000001000000000000000000000000 0000
0 7fffffffffffffffffffffffffffffff 00000000000000000000000000000001 80000000000000000000000000000000 0101
0 80000000000000000000000000000000 80000000000000000000000000000000 00000000000000000000000000000000 1110
0 ffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffff fffffffffffffffffffffffffffffffe 1001
0 0000000000000000ffffffff00000000 00000000000000000000000100000000 00000000000000010000000000000000 0000
0 0123456789abcdef0123456789abcdef 11111111111111111111111111111111 123456789abcdf00123456789abcdf00 0000
1 00000000000000000000000000000005 00000000000000000000000000000003 00000000000000000000000000000002 1000
1 00000000000000000000000000000003 00000000000000000000000000000005 fffffffffffffffffffffffffffffffe 0001
1 0123456789abcdef0123456789abcdef 0123456789abcdef0123456789abcdef 00000000000000000000000000000000 1010
1 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 1010
1 00000000000000000000000000000000 00000000000000000000000000000001 ffffffffffffffffffffffffffffffff 0001
1 80000000000000000000000000000000 00000000000000000000000000000001 7fffffffffffffffffffffffffffffff 1100
1 00000000000000000000000000000000 80000000000000000000000000000000 80000000000000000000000000000000 0101
1 7fffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffff 80000000000000000000000000000000 0101
1 00000001000000000000000000000000 00000000000000000000000000000001 00000000ffffffffffffffffffffffff 1000
1 ffffffffffffffffffffffffffffffff 00000000000000000000000000000001 fffffffffffffffffffffffffffffffe 1001
1 00000000000000000000000000000001 ffffffffffffffffffffffffffffffff 00000000000000000000000000000002 0000
1 123456789abcdf00123456789abcdf00 11111111111111111111111111111111 0123456789abcdef0123456789abcdef 1000
0 7fffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffff fffffffffffffffffffffffffffffffe 0101
1 80000000000000000000000000000000 80000000000000000000000000000000 00000000000000000000000000000000 1010
0 80000000000000000000000000000000 ffffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffff 1100
0 00000000ffffffff0000000000000000 00000000000000010000000000000000 00000001000000000000000000000000 0000
1 00000000000000000000000000000000 00000000000000000000000100000000 ffffffffffffffffffffffff00000000 0001
0 fedcba9876543210fedcba9876543210 0123456789abcdef0123456789abcdef ffffffffffffffffffffffffffffffff 0001
1 fedcba9876543210fedcba9876543210 0123456789abcdef0123456789abcdef fdb97530eca86421fdb97530eca86421 1001
0 00000000000000000000000080000000 00000000000000000000000080000000 00000000000000000000000100000000 0000
1 ffffffff000000000000000000000000 00000000000000000000000000000001 fffffffeffffffffffffffffffffffff 1001

/* filelist.f */
design/addsub_pkg.sv
design/brent_kung_adder.sv
design/operand_prep.sv
design/carry_lane_stage.sv
design/result_assembler.sv
design/wide_addsub_top.sv
test/tb_wide_addsub.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_wide_addsub
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

# Static checks only, no model is built.
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run; a $fatal in the testbench gives a failing exit status.
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
